// ==== all.f ====
logic/i2c_pkg.sv
logic/i2c_buffer.sv
logic/i2c_wb_regs.sv
logic/i2c_sequencer.sv
logic/i2c_line_ctrl.sv
logic/i2c_master.sv
bench/tb_clock_gen.sv
bench/i2c_target_model.sv
bench/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - logic/i2c_pkg.sv
  - logic/i2c_buffer.sv
  - logic/i2c_wb_regs.sv
  - logic/i2c_sequencer.sv
  - logic/i2c_line_ctrl.sv
  - logic/i2c_master.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/i2c_target_model.sv
      - bench/tb_i2c_master.sv

// ==== bench/tb_i2c_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the I2C master with Wishbone register port.
// Directed tests drive Wishbone accesses, run transfers against a
// behavioral target at 7'h2A and compare buffer and target contents
// with values kept by the bench. A cycle counter bounds the run.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_i2c_master import i2c_pkg::*; ();

    localparam int         CYCLE_LIMIT = 20000;
    localparam int         MEM_BYTES   = 16;
    localparam logic [6:0] TGT_ADDR    = 7'h2A;
    localparam logic [6:0] ABSENT_ADDR = 7'h11;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    tri1         sda_line;
    tri1         scl_line;
    logic [31:0] lcg_state;
    logic [7:0]  buf_exp [MEM_BYTES];  // Expected DUT buffer
    logic [7:0]  tgt_exp [MEM_BYTES];  // Expected target memory
    int          cycle_cnt = 0;

    tb_clock_gen clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    i2c_master #(
        .ADDR_W     (6),
        .MEM_BYTES  (MEM_BYTES),
        .IGNORE_ACK (0)
    ) i2c_master_inst (
        .I2C_CLK (clk),
        .RST     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .sda     (sda_line),
        .scl     (scl_line)
    );

    i2c_target_model #(
        .DEV_ADDR  (TGT_ADDR),
        .MEM_BYTES (MEM_BYTES)
    ) target_inst (
        .sda (sda_line),
        .scl (scl_line)
    );

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    function automatic logic [7:0] next_rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic expect_byte(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
        @(posedge clk);
        wb_req <= {1'b1, 1'b1, 1'b1, adr, dat};
        @(posedge clk);
        while (!wb_rsp.ack)
            @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [7:0] dat);
        @(posedge clk);
        wb_req <= {1'b1, 1'b1, 1'b0, adr, 8'h00};
        @(posedge clk);
        while (!wb_rsp.ack)
            @(posedge clk);
        dat = wb_rsp.dat;  // Data comes with ack
        wb_req <= '0;
    endtask

    task automatic expect_reg(input int adr, input logic [7:0] exp, input string what);
        logic [7:0] got;
        wb_read(8'(adr), got);
        expect_byte(what, got, exp);
    endtask

    task automatic readback_buffer(input string what);
        logic [7:0] got;
        for (int i = 0; i < MEM_BYTES; i++) begin
            wb_read(8'(BUF_BASE + i), got);
            expect_byte($sformatf("%s, buffer byte %0d", what, i), got, buf_exp[i]);
        end
    endtask

    task automatic verify_target_mem(input string what);
        for (int i = 0; i < MEM_BYTES; i++)
            expect_byte($sformatf("%s, target byte %0d", what, i),
                        target_inst.mem[i], tgt_exp[i]);
    endtask

    // Program address and size, start, then poll status until done
    task automatic run_transfer(input logic [7:0] addr_byte, input logic [15:0] size,
                                output logic [7:0] status);
        wb_write(8'(REG_ADDR), addr_byte);
        wb_write(8'(REG_SIZE_LO), size[7:0]);
        wb_write(8'(REG_SIZE_HI), size[15:8]);
        wb_write(8'(REG_START), 8'h01);
        status = 8'h00;
        while (!status[0])
            wb_read(8'(REG_START), status);
    endtask

    task automatic preload_target();
        for (int i = 0; i < MEM_BYTES; i++) begin
            tgt_exp[i]         = next_rand_byte();
            target_inst.mem[i] = tgt_exp[i];
        end
    endtask

    task automatic verify_reset_values();
        expect_reg(REG_CTRL, CORE_VERSION, "core version");
        expect_reg(REG_START, 8'h01, "status after reset");  // done 1, no_ack 0
        wb_write(8'(REG_ADDR), 8'hA7);
        expect_reg(REG_ADDR, 8'hA7, "address register");
    endtask

    task automatic buffer_loopback();
        for (int i = 0; i < MEM_BYTES; i++) begin
            buf_exp[i] = next_rand_byte();
            wb_write(8'(BUF_BASE + i), buf_exp[i]);
        end
        readback_buffer("loopback");
    endtask

    task automatic read_from_target();
        logic [7:0] status;
        run_transfer({TGT_ADDR, 1'b1}, 16'd6, status);
        expect_byte("status after read", status & 8'h07, 8'h01);
        for (int i = 0; i < 6; i++)
            buf_exp[i] = tgt_exp[i];
        readback_buffer("read transfer");
    endtask

    task automatic write_to_target();
        logic [7:0] status;
        for (int i = 0; i < 8; i++) begin
            buf_exp[i] = next_rand_byte();  // Fresh bytes the target does not hold
            wb_write(8'(BUF_BASE + i), buf_exp[i]);
        end
        run_transfer({TGT_ADDR, 1'b0}, 16'd8, status);
        expect_byte("status after write", status & 8'h07, 8'h01);
        for (int i = 0; i < 8; i++)
            tgt_exp[i] = buf_exp[i];
        verify_target_mem("write transfer");
        readback_buffer("after write");
    endtask

    task automatic absent_target_nack();
        logic [7:0] status;
        run_transfer({ABSENT_ADDR, 1'b0}, 16'd4, status);
        expect_byte("status after nack", status & 8'h07, 8'h03);
        verify_target_mem("absent address");
    endtask

    task automatic soft_reset_clears_regs();
        wb_write(8'(REG_ADDR), 8'h3C);
        wb_write(8'(REG_OPT), 8'h01);
        expect_reg(REG_ADDR, 8'h3C, "address before soft reset");
        expect_reg(REG_OPT, 8'h01, "options before soft reset");
        expect_reg(REG_SIZE_LO, 8'h04, "size before soft reset");
        wb_write(8'(REG_CTRL), 8'h00);
        expect_reg(REG_ADDR, 8'h00, "address after soft reset");
        expect_reg(REG_OPT, 8'h00, "options after soft reset");
        expect_reg(REG_SIZE_LO, 8'h00, "size after soft reset");
        readback_buffer("after soft reset");
    endtask

    initial begin
        wb_req    = '0;
        lcg_state = 32'hbdc1;
        preload_target();
        wait (rst == 1'b0);
        verify_reset_values();
        buffer_loopback();
        read_from_target();  // Before any write, target holds preload
        write_to_target();
        absent_target_nack();
        soft_reset_clears_regs();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== bench/i2c_target_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral I2C target for the master testbench.
// Acks its own 7-bit address, stores written bytes from index 0 after
// each start and returns stored bytes on reads until the master NACKs.
// The testbench preloads the memory through the hierarchy.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_target_model #(
    parameter logic [6:0] DEV_ADDR  = 7'h2A,
    parameter int         MEM_BYTES = 16
) (
    inout wire sda,
    input wire scl
);

    typedef enum logic [1:0] {T_IDLE, T_ADDR, T_WRITE, T_READ} tgt_state_t;

    tgt_state_t state;
    logic [7:0] mem [MEM_BYTES];
    logic [7:0] shift_reg;
    logic [7:0] tx_byte;
    logic       sda_low;
    logic       master_ack;
    int         bit_cnt;
    int         ptr;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        state   = T_IDLE;
        sda_low = 1'b0;
        bit_cnt = 0;
        ptr     = 0;
    end

    task automatic load_tx();
        tx_byte = mem[ptr % MEM_BYTES];
        ptr     = ptr + 1;
        sda_low = !tx_byte[7];  // MSB goes out first
    endtask

    // Start condition
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            state   = T_ADDR;
            bit_cnt = -1;  // First SCL fall ends the start, not a bit
            ptr     = 0;
            sda_low = 1'b0;
        end
    end

    // Stop condition
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            state   = T_IDLE;
            sda_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (state != T_IDLE && bit_cnt >= 0 && bit_cnt < 8)
            shift_reg = {shift_reg[6:0], sda};
        if (state == T_READ && bit_cnt == 8)
            master_ack = (sda === 1'b0);
    end

    always @(negedge scl) begin
        if (state != T_IDLE) begin
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                case (state)
                    T_ADDR: begin
                        if (shift_reg[7:1] == DEV_ADDR)
                            sda_low = 1'b1;
                        else
                            state = T_IDLE;  // Not ours
                    end
                    T_WRITE: begin
                        mem[ptr % MEM_BYTES] = shift_reg;
                        ptr     = ptr + 1;
                        sda_low = 1'b1;
                    end
                    default: sda_low = 1'b0;  // Master acks read byte
                endcase
            end else if (bit_cnt == 9) begin
                bit_cnt = 0;
                case (state)
                    T_ADDR: begin
                        if (shift_reg[0]) begin
                            state = T_READ;
                            load_tx();
                        end else begin
                            state   = T_WRITE;
                            sda_low = 1'b0;
                        end
                    end
                    T_WRITE: sda_low = 1'b0;
                    default: begin
                        if (master_ack) begin
                            load_tx();
                        end else begin
                            state   = T_IDLE;
                            sda_low = 1'b0;
                        end
                    end
                endcase
            end else if (state == T_READ && bit_cnt > 0) begin
                sda_low = !tx_byte[7 - bit_cnt];
            end
        end
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock and reset source for the I2C master testbench.
// 8 ns clock period, reset held high for the first 10 rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;  // Released on a rising edge
    end

endmodule

// ==== logic/i2c_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the I2C master with Wishbone classic register port.
// Chain of register block, sequencer and line controller, with the
// byte buffer shared by the register block and the sequencer.
// SDA and SCL need external pull-ups.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_master import i2c_pkg::*; #(
    parameter int ADDR_W     = 6,
    parameter int MEM_BYTES  = 16,
    parameter int IGNORE_ACK = 0
) (
    input  logic    I2C_CLK,
    input  logic    RST,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    inout  wire     sda,
    inout  wire     scl
);

    xfer_cfg_t  cfg;
    xfer_stat_t stat;
    logic       start;
    logic       soft_rst;
    buf_port_t  buf_a;
    buf_port_t  buf_b;
    logic [7:0] buf_a_rdata;
    logic [7:0] buf_b_rdata;
    line_cmd_t  cmd;
    phase_t     phase;
    logic       sda_sample;
    logic       bit_in;

    i2c_wb_regs #(
        .ADDR_W    (ADDR_W),
        .MEM_BYTES (MEM_BYTES)
    ) i2c_wb_regs_inst (
        .I2C_CLK     (I2C_CLK),
        .RST         (RST),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .cfg         (cfg),
        .start       (start),
        .soft_rst    (soft_rst),
        .stat        (stat),
        .buf_a       (buf_a),
        .buf_a_rdata (buf_a_rdata)
    );

    i2c_buffer #(.MEM_BYTES(MEM_BYTES)) i2c_buffer_inst (
        .I2C_CLK (I2C_CLK),
        .port_a  (buf_a),
        .rdata_a (buf_a_rdata),
        .port_b  (buf_b),
        .rdata_b (buf_b_rdata)
    );

    i2c_sequencer i2c_sequencer_inst (
        .I2C_CLK     (I2C_CLK),
        .RST         (RST),
        .soft_rst    (soft_rst),
        .start       (start),
        .cfg         (cfg),
        .phase       (phase),
        .sda_sample  (sda_sample),
        .bit_in      (bit_in),
        .cmd         (cmd),
        .buf_b       (buf_b),
        .buf_b_rdata (buf_b_rdata),
        .stat        (stat)
    );

    i2c_line_ctrl #(.IGNORE_ACK(IGNORE_ACK)) i2c_line_ctrl_inst (
        .I2C_CLK    (I2C_CLK),
        .RST        (RST),
        .soft_rst   (soft_rst),
        .cmd        (cmd),
        .phase      (phase),
        .sda_sample (sda_sample),
        .bit_in     (bit_in),
        .sda        (sda),
        .scl        (scl)
    );

endmodule

// ==== logic/i2c_line_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit-level driver for the I2C lines.
// A free quarter-phase counter splits each bit into four clocks. SDA
// and SCL are registered at their phases and driven open drain, SDA is
// sampled once for acknowledge and once for read data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_line_ctrl import i2c_pkg::*; #(
    parameter int IGNORE_ACK = 0
) (
    input  logic      I2C_CLK,
    input  logic      RST,
    input  logic      soft_rst,
    input  line_cmd_t cmd,
    output phase_t    phase,
    output logic      sda_sample,
    output logic      bit_in,
    inout  wire       sda,
    inout  wire       scl
);

    phase_t phase_cnt;
    logic   sda_q;
    logic   scl_q;

    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            phase_cnt <= PH_SDA_SET;
            sda_q     <= 1'b1;
            scl_q     <= 1'b1;
        end else begin
            phase_cnt <= phase_cnt + 2'd1;
            if (phase_cnt == PH_SDA_SET)
                sda_q <= cmd.sda_high;
            if (phase_cnt == PH_SCL_REL)
                scl_q <= 1'b1;
            else if (phase_cnt == PH_STEP)
                scl_q <= !cmd.scl_low;
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (phase_cnt == PH_SCL_REL)
            sda_sample <= (IGNORE_ACK != 0) ? 1'b0 : sda;
        if (phase_cnt == PH_STEP)
            bit_in <= sda;  // SCL high, data stable
    end

    assign phase = phase_cnt;

    // Open-drain outputs with external pull-ups
    assign sda = sda_q ? 1'bz : 1'b0;
    assign scl = scl_q ? 1'bz : 1'b0;

endmodule

// ==== logic/i2c_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transfer FSM of the I2C master.
// Steps once per bit at the last quarter phase: start, address, ack,
// data bytes in either direction, then an optional stop. Moves bytes
// through buffer port B and pulses done and no_ack at the end.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_sequencer import i2c_pkg::*; (
    input  logic       I2C_CLK,
    input  logic       RST,
    input  logic       soft_rst,
    input  logic       start,
    input  xfer_cfg_t  cfg,
    input  phase_t     phase,
    input  logic       sda_sample,
    input  logic       bit_in,
    output line_cmd_t  cmd,
    output buf_port_t  buf_b,
    input  logic [7:0] buf_b_rdata,
    output xfer_stat_t stat
);

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_ADDR, S_AACK, S_DATA_W,
        S_DATA_R, S_DACK_W, S_DACK_R, S_STOP
    } state_t;

    state_t      state;
    state_t      state_d;
    logic        start_pend;
    logic [2:0]  bit_cnt;
    logic [15:0] byte_cnt;
    logic [7:0]  rx_byte;
    logic        step;
    logic        last_byte;

    assign step      = (phase == PH_STEP);
    assign last_byte = (byte_cnt == cfg.size);

    always_comb begin
        state_d = state;
        case (state)
            S_IDLE:   if (start_pend) state_d = S_START;
            S_START:  state_d = S_ADDR;
            S_ADDR:   if (bit_cnt == 3'd7) state_d = S_AACK;
            S_AACK: begin
                if (sda_sample)
                    state_d = S_STOP;  // Nobody answered
                else
                    state_d = cfg.addr_byte[0] ? S_DATA_R : S_DATA_W;
            end
            S_DATA_W: if (bit_cnt == 3'd7) state_d = S_DACK_W;
            S_DATA_R: if (bit_cnt == 3'd7) state_d = S_DACK_R;
            S_DACK_W: begin
                if (sda_sample)
                    state_d = S_STOP;
                else if (last_byte)
                    state_d = cfg.no_stop ? S_IDLE : S_STOP;
                else
                    state_d = S_DATA_W;
            end
            S_DACK_R: begin
                if (last_byte)
                    state_d = cfg.no_stop ? S_IDLE : S_STOP;
                else
                    state_d = S_DATA_R;
            end
            default:  state_d = S_IDLE;  // Stop and illegal codes
        endcase
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            state      <= S_IDLE;
            start_pend <= 1'b0;
            bit_cnt    <= 3'd0;
            byte_cnt   <= 16'd0;
        end else begin
            if (start && state == S_IDLE)
                start_pend <= 1'b1;
            else if (state != S_IDLE)
                start_pend <= 1'b0;  // Starts while busy are dropped
            if (step) begin
                state <= state_d;
                if (state inside {S_ADDR, S_DATA_W, S_DATA_R})
                    bit_cnt <= bit_cnt + 3'd1;
                else
                    bit_cnt <= 3'd0;
                if (state == S_IDLE)
                    byte_cnt <= 16'd0;
                else if (state_d inside {S_DACK_W, S_DACK_R} && state != state_d)
                    byte_cnt <= byte_cnt + 16'd1;
            end
        end
    end

    // bit_in lags one bit, so the ninth shift brings in bit 7
    always_ff @(posedge I2C_CLK) begin
        if (phase == PH_SDA_SET)
            rx_byte <= {rx_byte[6:0], bit_in};
    end

    // Prefetch next write byte in ack slots, store read byte in DACK_R
    assign buf_b.en    = (phase == PH_BUF) && (state inside {S_AACK, S_DACK_W, S_DACK_R});
    assign buf_b.we    = (state == S_DACK_R);
    assign buf_b.addr  = buf_b.we ? byte_cnt - 16'd1 : byte_cnt;
    assign buf_b.wdata = rx_byte;

    always_comb begin
        cmd.scl_low  = 1'b1;
        cmd.sda_high = 1'b1;
        case (state)
            S_IDLE:   cmd.scl_low = 1'b0;
            S_START:  cmd.sda_high = 1'b0;
            S_ADDR:   cmd.sda_high = cfg.addr_byte[~bit_cnt];  // MSB first
            S_DATA_W: cmd.sda_high = buf_b_rdata[~bit_cnt];
            S_DACK_R: cmd.sda_high = last_byte;  // NACK the final byte
            S_STOP: begin
                cmd.scl_low  = 1'b0;
                cmd.sda_high = 1'b0;
            end
            default:  ;
        endcase
    end

    assign stat.done   = step && ((state == S_STOP) ||
                         (state_d == S_IDLE && state inside {S_DACK_W, S_DACK_R}));
    assign stat.no_ack = step && sda_sample && (state inside {S_AACK, S_DACK_W});

endmodule

// ==== logic/i2c_wb_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic register port of the I2C master.
// Holds target address, byte count and options, keeps sticky done and
// no-acknowledge flags, and maps offsets from BUF_BASE onto buffer
// port A. Every access is acked one cycle after it is first seen.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_wb_regs import i2c_pkg::*; #(
    parameter int ADDR_W    = 6,
    parameter int MEM_BYTES = 16
) (
    input  logic       I2C_CLK,
    input  logic       RST,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output xfer_cfg_t  cfg,
    output logic       start,
    output logic       soft_rst,
    input  xfer_stat_t stat,
    output buf_port_t  buf_a,
    input  logic [7:0] buf_a_rdata
);

    logic [ADDR_W-1:0] adr;
    logic [ADDR_W-1:0] adr_q;
    logic              valid;
    logic              ack_q;
    logic              wr;
    logic              is_buf;
    logic [7:0]        addr_reg;
    logic [7:0]        size_lo;
    logic [7:0]        size_hi;
    logic              no_stop;
    logic              done;
    logic              no_ack;
    logic [7:0]        reg_dat;
    logic [7:0]        reg_dat_q;

    assign adr    = wb_req.adr[ADDR_W-1:0];
    assign valid  = wb_req.cyc && wb_req.stb;
    assign wr     = valid && wb_req.we && ack_q;  // Writes land on the ack edge
    assign is_buf = (adr >= BUF_BASE) && (adr < BUF_BASE + MEM_BYTES);

    assign start    = wr && (adr == REG_START);
    assign soft_rst = wr && (adr == REG_CTRL);

    always_ff @(posedge I2C_CLK) begin
        if (RST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= valid && !ack_q;
        end
    end

    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            addr_reg <= 8'h00;
            size_lo  <= 8'h00;
            size_hi  <= 8'h00;
            no_stop  <= 1'b0;
        end else if (wr) begin
            case (adr)
                REG_ADDR:    addr_reg <= wb_req.dat;
                REG_SIZE_LO: size_lo  <= wb_req.dat;
                REG_SIZE_HI: size_hi  <= wb_req.dat;
                REG_OPT:     no_stop  <= wb_req.dat[0];
                default:     ;
            endcase
        end
    end

    // Sticky flags cleared by a new start
    always_ff @(posedge I2C_CLK) begin
        if (RST || soft_rst) begin
            done   <= 1'b1;
            no_ack <= 1'b0;
        end else if (start) begin
            done   <= 1'b0;
            no_ack <= 1'b0;
        end else begin
            if (stat.done)
                done <= 1'b1;
            if (stat.no_ack)
                no_ack <= 1'b1;
        end
    end

    always_comb begin
        case (adr)
            REG_CTRL:    reg_dat = CORE_VERSION;
            REG_START:   reg_dat = {5'b0, no_stop, no_ack, done};
            REG_ADDR:    reg_dat = addr_reg;
            REG_SIZE_LO: reg_dat = size_lo;
            REG_SIZE_HI: reg_dat = size_hi;
            REG_OPT:     reg_dat = {7'b0, no_stop};
            default:     reg_dat = 8'h00;
        endcase
    end

    // Captured when the access is first seen and shown with ack
    always_ff @(posedge I2C_CLK) begin
        if (valid && !ack_q) begin
            adr_q     <= adr;
            reg_dat_q <= reg_dat;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = (adr_q >= BUF_BASE) ? buf_a_rdata : reg_dat_q;

    // Reads fetch on the first cycle, writes commit with ack
    assign buf_a.en    = valid && is_buf && (wb_req.we ? ack_q : !ack_q);
    assign buf_a.we    = wb_req.we;
    assign buf_a.addr  = 16'(adr) - 16'(BUF_BASE);
    assign buf_a.wdata = wb_req.dat;

    assign cfg.addr_byte = addr_reg;
    assign cfg.size      = {size_hi, size_lo};
    assign cfg.no_stop   = no_stop;

endmodule

// ==== logic/i2c_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port byte buffer between the register port and the sequencer.
// Each port reads one cycle after en and returns the old contents
// when it writes the same address.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_buffer import i2c_pkg::*; #(
    parameter int MEM_BYTES = 16
) (
    input  logic       I2C_CLK,
    input  buf_port_t  port_a,
    output logic [7:0] rdata_a,
    input  buf_port_t  port_b,
    output logic [7:0] rdata_b
);

    localparam int AW = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;

    logic [7:0] mem [MEM_BYTES];

    always_ff @(posedge I2C_CLK) begin
        if (port_a.en) begin
            if (port_a.we)
                mem[port_a.addr[AW-1:0]] <= port_a.wdata;
            rdata_a <= mem[port_a.addr[AW-1:0]];
        end
        if (port_b.en) begin
            if (port_b.we)
                mem[port_b.addr[AW-1:0]] <= port_b.wdata;
            rdata_b <= mem[port_b.addr[AW-1:0]];
        end
    end

endmodule

// ==== logic/i2c_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the I2C master core.
// Wishbone request and response, transfer settings, buffer access,
// line commands, quarter-phase encoding and the register map.
// Modules pull these in with a wildcard import in their header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i2c_pkg;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [7:0] adr;  // Low ADDR_W bits select the register
        logic [7:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [7:0]  addr_byte;  // {target address, read flag}
        logic [15:0] size;
        logic        no_stop;
    } xfer_cfg_t;

    typedef struct packed {
        logic done;
        logic no_ack;
    } xfer_stat_t;

    typedef struct packed {
        logic        en;
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } buf_port_t;

    typedef struct packed {
        logic scl_low;
        logic sda_high;
    } line_cmd_t;

    typedef logic [1:0] phase_t;

    localparam phase_t PH_SDA_SET = 2'd0;  // SDA takes new level
    localparam phase_t PH_SCL_REL = 2'd1;  // SCL released, ACK sampled
    localparam phase_t PH_BUF     = 2'd2;  // Buffer access slot
    localparam phase_t PH_STEP    = 2'd3;  // State step, data sampled

    localparam int REG_CTRL    = 0;
    localparam int REG_START   = 1;
    localparam int REG_ADDR    = 2;
    localparam int REG_SIZE_LO = 3;
    localparam int REG_SIZE_HI = 4;
    localparam int REG_OPT     = 5;
    localparam int BUF_BASE    = 8;

    localparam logic [7:0] CORE_VERSION = 8'd1;

endpackage
